// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_icmp_echo
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation executable from the file list.
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# run from the project root so the test data path resolves.
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+include
hdl/icmp_pkg.sv
hdl/icmp_payload_fifo.sv
hdl/icmp_echo_rx.sv
hdl/icmp_echo_tx.sv
hdl/icmp_echo_top.sv
testbench/tb_icmp_echo.sv

// ==== hdl/icmp_echo_rx.sv ====
`include "icmp_settings.svh"

module icmp_echo_rx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  icmp_pkg::byte_strm_t   in_strm,
  input  icmp_pkg::rx_meta_t     in_meta,
  input  logic                   busy,
  output icmp_pkg::byte_strm_t   pkt_strm,
  output icmp_pkg::icmp_meta_t   pkt_meta
);

  import icmp_pkg::*;

  localparam int cnt_w = $clog2(`ICMP_HDR_LEN);

  rx_state_t                     state;
  logic [cnt_w-1:0]              byte_cnt;
  logic [`ICMP_HDR_LEN-1:0][7:0] hdr_q;
  rx_meta_t                      meta_q;
  logic                          pld_first;
  logic                          hdr_ok;
  logic                          hdr_shift;
  logic                          fwd;

  // type sits one byte below the top once seven bytes are in, code below it.
  assign hdr_ok = (hdr_q[`ICMP_HDR_LEN-2] == `ICMP_TYPE_ECHO_REQ) &&
                  (hdr_q[`ICMP_HDR_LEN-3] == 8'h00);

  assign hdr_shift = in_strm.val &&
                     (((state == idle) && in_strm.sof) || (state == header));

  always_ff @(posedge clk) begin
    if (hdr_shift) hdr_q <= {hdr_q[`ICMP_HDR_LEN-2:0], in_strm.dat};
    if ((state == idle) && in_strm.val && in_strm.sof) meta_q <= in_meta;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= idle;
      byte_cnt  <= '0;
      pld_first <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (in_strm.val && in_strm.sof) begin
            byte_cnt <= cnt_w'(1);
            if (in_strm.eof) state <= idle; // runt packet.
            else if (in_strm.err) state <= drop;
            else state <= header;
          end
        end
        header: begin
          if (in_strm.val) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (in_strm.eof) begin
              state <= idle; // short header or empty payload.
            end else if (in_strm.err) begin
              state <= drop;
            end else if (byte_cnt == cnt_w'(`ICMP_HDR_LEN - 1)) begin
              if (hdr_ok && !busy) begin
                state     <= payload;
                pld_first <= 1'b1;
              end else begin
                state <= drop;
              end
            end
          end
        end
        payload: begin
          if (in_strm.val) begin
            pld_first <= 1'b0;
            if (in_strm.eof) state <= idle;
            else if (in_strm.err) state <= drop; // err beat still goes out.
          end
        end
        drop: begin
          if (in_strm.val && in_strm.eof) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  assign fwd = in_strm.val && (state == payload);

  always_comb begin
    pkt_strm.dat = in_strm.dat;
    pkt_strm.val = fwd;
    pkt_strm.sof = fwd && pld_first;
    pkt_strm.eof = fwd && in_strm.eof;
    pkt_strm.err = fwd && in_strm.err;
  end

  always_comb begin
    pkt_meta.rx_meta  = meta_q;
    pkt_meta.icmp_hdr = icmp_hdr_t'(hdr_q);
    pkt_meta.pld_len  = meta_q.ipv4_hdr.length - 16'(20 + `ICMP_HDR_LEN); // ihl of 5.
  end

  a_fwd_echo_only : assert property (@(posedge clk) disable iff (fsm_rst)
    pkt_strm.sof |-> (pkt_meta.icmp_hdr.icmp_type == `ICMP_TYPE_ECHO_REQ) &&
                     (pkt_meta.icmp_hdr.icmp_code == 8'h00) && !busy)
    else $error("payload forwarded for a packet that should be dropped.");

endmodule

// ==== hdl/icmp_echo_top.sv ====
`include "icmp_settings.svh"

module icmp_echo_top (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  icmp_pkg::dev_t       dev,
  input  icmp_pkg::byte_strm_t in_strm,
  input  icmp_pkg::rx_meta_t   in_meta,
  input  logic                 req,
  output logic                 rdy,
  output icmp_pkg::byte_strm_t out_strm,
  output icmp_pkg::ipv4_meta_t out_meta,
  output logic                 done
);

  import icmp_pkg::*;

  byte_strm_t pkt_strm;
  icmp_meta_t pkt_meta;
  logic       busy;

  icmp_echo_rx i_rx (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .in_strm  (in_strm),
    .in_meta  (in_meta),
    .busy     (busy),
    .pkt_strm (pkt_strm),
    .pkt_meta (pkt_meta)
  );

  icmp_echo_tx i_tx (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev      (dev),
    .pkt_strm (pkt_strm),
    .pkt_meta (pkt_meta),
    .busy     (busy),
    .req      (req),
    .rdy      (rdy),
    .out_strm (out_strm),
    .out_meta (out_meta),
    .done     (done)
  );

  // the whole payload must fit in the fifo before req may arrive.
  a_pld_fits : assert property (@(posedge clk) disable iff (fsm_rst)
    (pkt_strm.val && pkt_strm.sof) |-> (pkt_meta.pld_len <= 16'(`ICMP_FIFO_DEPTH)))
    else $error("echo payload exceeds the fifo depth.");

endmodule

// ==== hdl/icmp_echo_tx.sv ====
`include "icmp_settings.svh"

module icmp_echo_tx (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  icmp_pkg::dev_t       dev,
  input  icmp_pkg::byte_strm_t pkt_strm,
  input  icmp_pkg::icmp_meta_t pkt_meta,
  output logic                 busy,
  input  logic                 req,
  output logic                 rdy,
  output icmp_pkg::byte_strm_t out_strm,
  output icmp_pkg::ipv4_meta_t out_meta,
  output logic                 done
);

  import icmp_pkg::*;

  localparam int cnt_w = $clog2(`ICMP_HDR_LEN);

  logic [`ICMP_HDR_LEN-1:0][7:0] hdr_sr;
  icmp_hdr_t                     reply_hdr;
  ipv4_meta_t                    reply_meta;
  logic [16:0]                   cks_sum;
  logic [cnt_w-1:0]              hdr_cnt;
  logic                          started;
  logic                          launch;
  logic                          out_val;
  logic                          out_sof;
  logic                          pld_phase;
  logic                          rd_active;
  logic                          overflow;
  logic                          reply_end;
  logic                          blk_rst;
  logic                          fifo_write;
  logic                          fifo_read;
  logic                          fifo_empty;
  logic                          fifo_full;
  logic [7:0]                    fifo_dout;

  // type 8 -> 0 changes one checksum word by 0x0800, end-around carry.
  assign cks_sum = {1'b0, pkt_meta.icmp_hdr.icmp_cks} + 17'h0_0800;

  always_comb begin
    reply_hdr.icmp_type = `ICMP_TYPE_ECHO_REPLY;
    reply_hdr.icmp_code = 8'h00;
    reply_hdr.icmp_cks  = cks_sum[15:0] + {15'd0, cks_sum[16]};
    reply_hdr.icmp_id   = pkt_meta.icmp_hdr.icmp_id;
    reply_hdr.icmp_seq  = pkt_meta.icmp_hdr.icmp_seq;
  end

  always_comb begin
    reply_meta                   = '0; // zero, df, mf, fo and cks stay cleared.
    reply_meta.mac_hdr.dst_mac   = pkt_meta.rx_meta.mac_hdr.src_mac;
    reply_meta.mac_hdr.src_mac   = dev.mac_addr;
    reply_meta.mac_hdr.ethertype = pkt_meta.rx_meta.mac_hdr.ethertype;
    reply_meta.ipv4_hdr.ver      = 4'd4;
    reply_meta.ipv4_hdr.ihl      = 4'd5;
    reply_meta.ipv4_hdr.qos      = pkt_meta.rx_meta.ipv4_hdr.qos;
    reply_meta.ipv4_hdr.length   = pkt_meta.rx_meta.ipv4_hdr.length;
    reply_meta.ipv4_hdr.id       = pkt_meta.rx_meta.ipv4_hdr.id;
    reply_meta.ipv4_hdr.ttl      = `IPV4_REPLY_TTL;
    reply_meta.ipv4_hdr.proto    = pkt_meta.rx_meta.ipv4_hdr.proto;
    reply_meta.ipv4_hdr.src_ip   = dev.ipv4_addr;
    reply_meta.ipv4_hdr.dst_ip   = pkt_meta.rx_meta.ipv4_hdr.src_ip;
    reply_meta.mac_known         = 1'b1;
    reply_meta.pld_len           = pkt_meta.pld_len;
  end

  assign overflow   = pkt_strm.val && fifo_full; // payload longer than the fifo.
  assign reply_end  = out_strm.eof || (pkt_strm.val && pkt_strm.err) || overflow;
  assign blk_rst    = fsm_rst || reply_end;
  assign fifo_write = pkt_strm.val && !fifo_full;
  assign fifo_read  = rd_active && !fifo_empty;

  icmp_payload_fifo i_fifo (
    .clk      (clk),
    .fsm_rst  (blk_rst),
    .write    (fifo_write),
    .data_in  (pkt_strm.dat),
    .read     (fifo_read),
    .data_out (fifo_dout),
    .empty    (fifo_empty),
    .full     (fifo_full)
  );

  always_ff @(posedge clk) begin
    if (pkt_strm.val && pkt_strm.sof) begin
      hdr_sr   <= reply_hdr;
      out_meta <= reply_meta;
    end else if (out_val && !pld_phase) begin
      hdr_sr <= {hdr_sr[`ICMP_HDR_LEN-2:0], 8'h00};
    end
  end

  always_ff @(posedge clk) begin
    if (blk_rst) begin
      rdy       <= 1'b0;
      busy      <= 1'b0;
      started   <= 1'b0;
      launch    <= 1'b0;
      out_val   <= 1'b0;
      out_sof   <= 1'b0;
      hdr_cnt   <= '0;
      pld_phase <= 1'b0;
      rd_active <= 1'b0;
    end else begin
      if (pkt_strm.val && pkt_strm.sof) begin
        rdy  <= 1'b1;
        busy <= 1'b1;
      end
      launch  <= rdy && req && !started; // only the first req counts.
      if (rdy && req) started <= 1'b1;
      out_sof <= launch;
      if (launch) out_val <= 1'b1;
      if (out_val && !pld_phase) begin
        hdr_cnt <= hdr_cnt + 1'b1;
        if (hdr_cnt == cnt_w'(`ICMP_HDR_LEN - 2)) rd_active <= 1'b1; // fifo data lags a cycle.
        if (hdr_cnt == cnt_w'(`ICMP_HDR_LEN - 1)) pld_phase <= 1'b1;
      end
    end
  end

  always_comb begin
    out_strm.dat = pld_phase ? fifo_dout : hdr_sr[`ICMP_HDR_LEN-1];
    out_strm.val = out_val;
    out_strm.sof = out_sof;
    out_strm.eof = out_val && pld_phase && fifo_empty; // last byte has left the fifo.
    out_strm.err = 1'b0;
  end

  assign done = out_strm.eof;

  a_sof_while_rdy : assert property (@(posedge clk) disable iff (fsm_rst)
    out_strm.sof |-> rdy)
    else $error("reply started without rdy.");

endmodule

// ==== hdl/icmp_payload_fifo.sv ====
`include "icmp_settings.svh"

module icmp_payload_fifo (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       write,
  input  logic [7:0] data_in,
  input  logic       read,
  output logic [7:0] data_out,
  output logic       empty,
  output logic       full
);

  localparam int depth = `ICMP_FIFO_DEPTH;
  localparam int addr_w = $clog2(depth);

  logic [7:0]        mem [depth];
  logic [addr_w-1:0] wr_ptr;
  logic [addr_w-1:0] rd_ptr;
  logic [addr_w:0]   level;
  logic              wr_en;
  logic              rd_en;

  function automatic logic [addr_w-1:0] next_ptr(input logic [addr_w-1:0] ptr);
    return (ptr == addr_w'(depth - 1)) ? '0 : ptr + 1'b1; // wraps for any depth.
  endfunction

  assign empty = (level == '0);
  assign full  = (level == (addr_w + 1)'(depth));
  assign wr_en = write && !full;
  assign rd_en = read && !empty;

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= data_in;
    if (rd_en) data_out <= mem[rd_ptr]; // valid the cycle after read.
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (wr_en) wr_ptr <= next_ptr(wr_ptr);
      if (rd_en) rd_ptr <= next_ptr(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (fsm_rst) !(write && full))
    else $error("payload fifo written while full.");
  a_no_underflow : assert property (@(posedge clk) disable iff (fsm_rst) !(read && empty))
    else $error("payload fifo read while empty.");

endmodule

// ==== hdl/icmp_pkg.sv ====
package icmp_pkg;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
    logic       err;
  } byte_strm_t;

  typedef struct packed {
    logic [5:0][7:0] dst_mac;
    logic [5:0][7:0] src_mac;
    logic [15:0]     ethertype;
  } mac_hdr_t;

  typedef struct packed {
    logic [3:0]      ver;
    logic [3:0]      ihl;
    logic [7:0]      qos;
    logic [15:0]     length;
    logic [15:0]     id;
    logic            zero;
    logic            df;
    logic            mf;
    logic [12:0]     fo;
    logic [7:0]      ttl;
    logic [7:0]      proto;
    logic [15:0]     cks;
    logic [3:0][7:0] src_ip;
    logic [3:0][7:0] dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] icmp_cks;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
  } icmp_hdr_t;

  typedef struct packed {
    mac_hdr_t  mac_hdr;
    ipv4_hdr_t ipv4_hdr;
  } rx_meta_t;

  typedef struct packed {
    rx_meta_t    rx_meta;
    icmp_hdr_t   icmp_hdr;
    logic [15:0] pld_len; // echo data bytes after the icmp header.
  } icmp_meta_t;

  typedef struct packed {
    mac_hdr_t    mac_hdr;
    ipv4_hdr_t   ipv4_hdr;
    logic        mac_known;
    logic [15:0] pld_len;
  } ipv4_meta_t;

  typedef struct packed {
    logic [3:0][7:0] ipv4_addr;
    logic [5:0][7:0] mac_addr;
  } dev_t;

  typedef enum logic [1:0] {
    idle,
    header,
    payload,
    drop
  } rx_state_t;

endpackage

// ==== include/icmp_settings.svh ====
`ifndef ICMP_SETTINGS_SVH
`define ICMP_SETTINGS_SVH

// icmp header, fixed size for echo messages.
`define ICMP_HDR_LEN 8

// payload bytes held between request and reply.
`define ICMP_FIFO_DEPTH 256

// ttl written into every outgoing reply.
`define IPV4_REPLY_TTL 8'd128

// echo message types.
`define ICMP_TYPE_ECHO_REQ 8'd8
`define ICMP_TYPE_ECHO_REPLY 8'd0

`endif

// ==== testbench/icmp_testdata.txt ====
# type code cks id seq src_ip src_mac pld_len req_delay err expect_reply
# first seven columns hex, last four decimal; err puts err on header byte 3.
08 00 1234 0001 0001 c0a80102 021122334455 16 0 0 1
08 00 fa12 0002 0002 c0a80103 021122334456 24 3 0 1
08 00 f800 0003 0003 c0a80104 021122334457 5 1 0 1
08 00 f7ff 0004 0004 c0a80105 021122334458 9 2 0 1
08 00 0000 0005 0005 0a000001 0a1b2c3d4e5f 64 120 0 1
08 00 5555 0006 0006 0a000002 0a1b2c3d4e60 20 0 0 0
08 00 abcd 0007 0007 0a000003 0a1b2c3d4e61 12 0 0 1
00 00 1111 0008 0008 0a000004 0a1b2c3d4e62 10 0 0 0
08 01 2222 0009 0009 0a000005 0a1b2c3d4e63 10 0 0 0
0d 00 3333 000a 000a 0a000006 0a1b2c3d4e64 12 0 0 0
08 00 4444 000b 000b ac100001 06aabbccdd01 8 4 0 1
08 00 5555 000c 000c ac100002 06aabbccdd02 16 0 1 0
08 00 ffff 000d 000d ac100003 06aabbccdd03 3 0 0 1
08 00 6666 000e 000e ac100004 06aabbccdd04 0 0 0 0
08 00 7777 000f 000f ac100005 06aabbccdd05 1 0 0 1
08 00 8800 0010 0010 c0a86401 0e0102030405 200 250 0 1
08 00 9999 0011 0011 c0a86402 0e0102030406 40 0 0 0
03 00 aaaa 0012 0012 c0a86403 0e0102030407 6 0 0 0
08 00 fedc 0013 0013 c0a86404 0e0102030408 33 7 0 1
08 00 0102 0014 0014 c0a86405 0e0102030409 2 0 0 1

// ==== testbench/tb_icmp_echo.sv ====
`include "icmp_settings.svh"

module tb_icmp_echo;

  import icmp_pkg::*;

  localparam int max_pkts = 64;

  logic       clk = 1'b0;
  logic       fsm_rst;
  dev_t       dev;
  byte_strm_t in_strm;
  rx_meta_t   in_meta;
  logic       req;
  logic       rdy;
  byte_strm_t out_strm;
  ipv4_meta_t out_meta;
  logic       done;

  // one slot per request line of the data file.
  logic [7:0]  t_type [max_pkts];
  logic [7:0]  t_code [max_pkts];
  logic [15:0] t_cks [max_pkts];
  logic [15:0] t_id [max_pkts];
  logic [15:0] t_seq [max_pkts];
  logic [31:0] t_ip [max_pkts];
  logic [47:0] t_mac [max_pkts];
  int          t_len [max_pkts];
  int          t_delay [max_pkts];
  int          t_err [max_pkts];
  int          t_exp [max_pkts];
  int          n_pkts;

  logic [7:0] exp_bytes [$]; // header then payload of every reply still due.
  ipv4_meta_t exp_meta [$];
  int         exp_beats [$];
  int         exp_delay [$];
  int         replies_open;
  int         budget_cycles;
  integer     seed;

  icmp_echo_top i_dut (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev      (dev),
    .in_strm  (in_strm),
    .in_meta  (in_meta),
    .req      (req),
    .rdy      (rdy),
    .out_strm (out_strm),
    .out_meta (out_meta),
    .done     (done)
  );

  always #20 clk = ~clk;

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  // one's complement add of the type change, carry folded back in.
  function automatic logic [15:0] reply_cks(input logic [15:0] req_cks);
    logic [16:0] sum;
    sum = {1'b0, req_cks} + 17'h0_0800;
    if (sum[16]) sum = {1'b0, sum[15:0]} + 17'd1;
    return sum[15:0];
  endfunction

  task automatic load_tests();
    int fd;
    int n;
    logic [8*128-1:0] line_buf;
    fd = $fopen("testbench/icmp_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/icmp_testdata.txt");
    end else begin
      n_pkts = 0;
      while (!$feof(fd) && n_pkts < max_pkts) begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        n = $sscanf(line_buf, "%h %h %h %h %h %h %h %d %d %d %d", t_type[n_pkts],
                    t_code[n_pkts], t_cks[n_pkts], t_id[n_pkts], t_seq[n_pkts], t_ip[n_pkts],
                    t_mac[n_pkts], t_len[n_pkts], t_delay[n_pkts], t_err[n_pkts],
                    t_exp[n_pkts]);
        if (n == 11) n_pkts++; // comment lines do not parse.
      end
      $fclose(fd);
    end
  endtask

  task automatic send_packet(input int k);
    logic [7:0] hdr [`ICMP_HDR_LEN];
    logic [7:0] pld [$];
    logic [15:0] cks;
    ipv4_meta_t m;
    int total;
    int b;
    logic collide;
    hdr = '{t_type[k], t_code[k], t_cks[k][15:8], t_cks[k][7:0],
            t_id[k][15:8], t_id[k][7:0], t_seq[k][15:8], t_seq[k][7:0]};
    for (b = 0; b < t_len[k]; b++) pld.push_back(8'($random(seed)));
    total = `ICMP_HDR_LEN + t_len[k];
    // a well formed request without a reply is meant to meet a busy transmitter.
    collide = (t_exp[k] == 0) && (t_type[k] == `ICMP_TYPE_ECHO_REQ) &&
              (t_code[k] == 8'h00) && (t_err[k] == 0) && (t_len[k] > 0);
    if (!collide) begin
      while (replies_open != 0) @(posedge clk); // everything else meets an idle transmitter.
    end
    if (t_exp[k] != 0) begin
      m = '0;
      m.mac_hdr.dst_mac  = t_mac[k];
      m.mac_hdr.src_mac  = dev.mac_addr;
      m.ipv4_hdr.ver     = 4'd4;
      m.ipv4_hdr.ihl     = 4'd5;
      m.ipv4_hdr.qos     = 8'(k * 4);
      m.ipv4_hdr.length  = 16'(20 + total);
      m.ipv4_hdr.id      = 16'h4000 + 16'(k);
      m.ipv4_hdr.ttl     = `IPV4_REPLY_TTL;
      m.ipv4_hdr.proto   = 8'd1;
      m.ipv4_hdr.src_ip  = dev.ipv4_addr;
      m.ipv4_hdr.dst_ip  = t_ip[k];
      m.pld_len          = 16'(t_len[k]);
      cks = reply_cks(t_cks[k]);
      exp_meta.push_back(m);
      exp_beats.push_back(total);
      exp_delay.push_back(t_delay[k]);
      exp_bytes.push_back(`ICMP_TYPE_ECHO_REPLY);
      exp_bytes.push_back(8'h00);
      exp_bytes.push_back(cks[15:8]);
      exp_bytes.push_back(cks[7:0]);
      for (b = 4; b < `ICMP_HDR_LEN; b++) exp_bytes.push_back(hdr[b]);
      for (b = 0; b < t_len[k]; b++) exp_bytes.push_back(pld[b]);
      replies_open++;
    end
    for (b = 0; b < total; b++) begin
      @(posedge clk);
      #2;
      if (b == 0) begin
        in_meta = '0;
        in_meta.mac_hdr.dst_mac   = dev.mac_addr;
        in_meta.mac_hdr.src_mac   = t_mac[k];
        in_meta.mac_hdr.ethertype = 16'h0800;
        in_meta.ipv4_hdr.ver      = 4'd4;
        in_meta.ipv4_hdr.ihl      = 4'd5;
        in_meta.ipv4_hdr.qos      = 8'(k * 4);
        in_meta.ipv4_hdr.length   = 16'(20 + total);
        in_meta.ipv4_hdr.id       = 16'h4000 + 16'(k);
        in_meta.ipv4_hdr.df       = 1'b1; // must come back cleared.
        in_meta.ipv4_hdr.ttl      = 8'd64;
        in_meta.ipv4_hdr.proto    = 8'd1;
        in_meta.ipv4_hdr.cks      = 16'hbeef;
        in_meta.ipv4_hdr.src_ip   = t_ip[k];
        in_meta.ipv4_hdr.dst_ip   = dev.ipv4_addr;
      end
      if (b < `ICMP_HDR_LEN) in_strm.dat = hdr[b];
      else in_strm.dat = pld[b - `ICMP_HDR_LEN];
      in_strm.val = 1'b1;
      in_strm.sof = (b == 0);
      in_strm.eof = (b == total - 1);
      in_strm.err = (t_err[k] != 0) && (b == 3);
    end
    @(posedge clk);
    #2;
    in_strm = '0;
    repeat (3) @(posedge clk);
  endtask

  // ipv4 side, called on the first cycle that shows rdy.
  task automatic serve_reply();
    ipv4_meta_t m;
    int beats;
    int i;
    m = exp_meta.pop_front();
    beats = exp_beats.pop_front();
    check(out_meta.mac_hdr.dst_mac, m.mac_hdr.dst_mac, "reply dst_mac");
    check(out_meta.mac_hdr.src_mac, m.mac_hdr.src_mac, "reply src_mac");
    check(out_meta.mac_hdr.ethertype, 16'h0800, "reply ethertype");
    check(out_meta.mac_known, 1'b1, "reply mac_known");
    check(out_meta.ipv4_hdr.dst_ip, m.ipv4_hdr.dst_ip, "reply dst_ip");
    check(out_meta.ipv4_hdr.src_ip, m.ipv4_hdr.src_ip, "reply src_ip");
    check(out_meta.ipv4_hdr.ttl, m.ipv4_hdr.ttl, "reply ttl");
    check(out_meta.ipv4_hdr.length, m.ipv4_hdr.length, "reply length");
    check(out_meta.ipv4_hdr.id, m.ipv4_hdr.id, "reply id");
    check(out_meta.ipv4_hdr.qos, m.ipv4_hdr.qos, "reply qos");
    check(out_meta.ipv4_hdr.proto, m.ipv4_hdr.proto, "reply proto");
    check({out_meta.ipv4_hdr.ver, out_meta.ipv4_hdr.ihl}, 8'h45, "reply ver and ihl");
    check({out_meta.ipv4_hdr.zero, out_meta.ipv4_hdr.df, out_meta.ipv4_hdr.mf,
           out_meta.ipv4_hdr.fo}, '0, "reply flags and fragment offset");
    check(out_meta.ipv4_hdr.cks, 16'h0000, "reply ipv4 cks");
    check(out_meta.pld_len, m.pld_len, "reply pld_len");
    @(posedge clk);
    repeat (exp_delay.pop_front()) @(posedge clk);
    #2;
    req = 1'b1;
    for (i = 0; i < 2; i++) begin
      @(negedge clk);
      check(out_strm.val, 1'b0, "beat before the start latency");
      check(rdy, 1'b1, "rdy held until the reply starts");
    end
    for (i = 0; i < beats; i++) begin
      @(negedge clk);
      check(out_strm.val, 1'b1, "gap in reply beats");
      check(out_strm.sof, i == 0, $sformatf("sof on beat %0d", i));
      check(out_strm.eof, i == beats - 1, $sformatf("eof on beat %0d", i));
      check(out_strm.err, 1'b0, $sformatf("err on beat %0d", i));
      check(done, i == beats - 1, $sformatf("done on beat %0d", i));
      check(out_strm.dat, exp_bytes.pop_front(), $sformatf("reply byte %0d", i));
    end
    @(posedge clk);
    #2;
    req = 1'b0;
    @(negedge clk);
    check(rdy, 1'b0, "rdy after eof");
    check(i_dut.busy, 1'b0, "busy after eof");
    check(out_strm.val, 1'b0, "val after eof");
    check(done, 1'b0, "done after eof");
    replies_open--;
  endtask

  initial begin : ipv4_layer
    req = 1'b0;
    wait (fsm_rst === 1'b0);
    forever begin
      @(negedge clk);
      if (rdy) begin
        if (exp_meta.size() == 0) abort_run("rdy raised for a packet that should be dropped");
        else serve_reply();
      end else if (out_strm.val || done) begin
        abort_run("reply beat seen while no reply was offered");
      end
    end
  end

  initial begin : watchdog
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("timeout after %0d cycles with %0d replies outstanding", budget_cycles,
             replies_open);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    int k;
    int budget;
    seed          = 32'h95b5_67cb;
    fsm_rst       = 1'b1;
    in_strm       = '0;
    in_meta       = '0;
    dev.ipv4_addr = 32'hc0a8_0a01;
    dev.mac_addr  = 48'h00_0a_35_01_02_03;
    replies_open  = 0;
    budget_cycles = 0;
    load_tests();
    if (n_pkts == 0) abort_run("no request lines found in the test data");
    budget = 16 + 200;
    for (k = 0; k < n_pkts; k++) budget += 2 * (20 + `ICMP_HDR_LEN + t_len[k]) + t_delay[k];
    budget_cycles = budget;
    repeat (16) @(posedge clk);
    #2;
    fsm_rst = 1'b0;
    repeat (10) begin
      @(negedge clk);
      check(rdy, 1'b0, "rdy with no input");
      check(i_dut.busy, 1'b0, "busy with no input");
      check(out_strm.val, 1'b0, "out val with no input");
      check(done, 1'b0, "done with no input");
    end
    for (k = 0; k < n_pkts; k++) send_packet(k);
    while (replies_open != 0) @(posedge clk);
    repeat (20) @(posedge clk); // late stray replies get caught by the ipv4 model.
    $display("TEST PASS");
    $finish;
  end

endmodule
